// ==== files.f ====
logic/snoop_data_pkg.sv
logic/cd_order_queue.sv
logic/cd_beat_tracker.sv
logic/cd_credit_out.sv
logic/snoop_data_ctrl.sv
tests/snoop_data_ctrl_properties.sv
tests/tb_snoop_data_ctrl.sv

// ==== logic/cd_beat_tracker.sv ====
//////////////////////////////////////////////////
// Snoop data beat tracker
// Accepts masked beats, forwards the first responder
//////////////////////////////////////////////////

module cd_beat_tracker #(
    parameter int unsigned NumMst    = 4,
    parameter int unsigned DataWidth = 64,
    localparam int unsigned IdxW     = (NumMst > 1) ? $clog2(NumMst) : 1
) (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    // Head of the ordering queue
    input  logic                                 head_valid_i,
    input  snoop_data_pkg::cd_user_e             head_user_i,
    input  logic [IdxW-1:0]                      head_first_i,
    input  logic [NumMst-1:0]                    head_avail_i,
    output logic                                 pop_o,
    // Credit state of the consumers
    input  logic                                 mem_has_credit_i,
    input  logic                                 snp_has_credit_i,
    // Snoop data channels
    input  logic [NumMst-1:0]                    cd_valid_i,
    input  logic [NumMst-1:0][DataWidth-1:0]     cd_data_i,
    input  logic [NumMst-1:0]                    cd_last_i,
    output logic [NumMst-1:0]                    cd_ready_o,
    // Forwarded beat
    output logic                                 fwd_valid_o,
    output snoop_data_pkg::cd_user_e             fwd_user_o,
    output logic [DataWidth-1:0]                 fwd_data_o,
    output logic                                 fwd_last_o
);
    import snoop_data_pkg::*;

    logic [NumMst-1:0] last_q;
    logic [NumMst-1:0] beat_hs;
    logic              head_credit;
    logic              done;

    assign head_credit = (head_user_i == USER_MEMORY) ? mem_has_credit_i : snp_has_credit_i;

    //////////////////////////////////////////////////
    // Ready per master
    //////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < NumMst; i++) begin
            cd_ready_o[i] = head_valid_i && head_avail_i[i] && !last_q[i];
            // First responder also waits for a credit
            if (head_first_i == IdxW'(i)) begin
                cd_ready_o[i] = cd_ready_o[i] && head_credit;
            end
        end
    end

    assign beat_hs = cd_valid_i & cd_ready_o;

    // All masked masters have sent last
    assign done  = head_valid_i && (last_q == head_avail_i);
    assign pop_o = done;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            last_q <= '0;
        end else if (done) begin
            last_q <= '0;
        end else begin
            last_q <= last_q | (beat_hs & cd_last_i);
        end
    end

    //////////////////////////////////////////////////
    // Forward path
    //////////////////////////////////////////////////

    assign fwd_valid_o = beat_hs[head_first_i];
    assign fwd_user_o  = head_user_i;
    assign fwd_data_o  = cd_data_i[head_first_i];
    assign fwd_last_o  = cd_last_i[head_first_i];

endmodule

// ==== logic/cd_credit_out.sv ====
//////////////////////////////////////////////////
// Snoop data output stage
// Registers forwarded beats, one credit pool per consumer
//////////////////////////////////////////////////

module cd_credit_out #(
    parameter int unsigned NumMst    = 4,
    parameter int unsigned DataWidth = 64,
    parameter int unsigned Credits   = 4
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    // Beat from the tracker
    input  logic                      fwd_valid_i,
    input  snoop_data_pkg::cd_user_e  fwd_user_i,
    input  logic [DataWidth-1:0]      fwd_data_i,
    input  logic                      fwd_last_i,
    // Credit returns
    input  logic                      mem_credit_i,
    input  logic                      snp_credit_i,
    output logic                      mem_has_credit_o,
    output logic                      snp_has_credit_o,
    // Consumer outputs
    output logic                      mem_valid_o,
    output logic                      snp_valid_o,
    output logic [DataWidth-1:0]      out_data_o,
    output logic                      out_last_o
);
    import snoop_data_pkg::*;

    localparam int unsigned CntW = $clog2(Credits + 1);

    if (NumMst == 0 || Credits == 0) begin : gen_param_check
        $error("Snoop data output stage needs at least one master and one credit");
    end

    // Indexed by consumer encoding
    logic [1:0]      strobe_q;
    logic [1:0]      credit_ret;
    logic [1:0]      has_credit;
    logic [CntW-1:0] credit_q [2];

    assign credit_ret[USER_MEMORY] = mem_credit_i;
    assign credit_ret[USER_SNOOP]  = snp_credit_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            strobe_q <= '0;
            for (int c = 0; c < 2; c++) begin
                credit_q[c] <= CntW'(Credits);
            end
        end else begin
            for (int c = 0; c < 2; c++) begin
                strobe_q[c] <= fwd_valid_i && (fwd_user_i == cd_user_e'(c));
                credit_q[c] <= credit_q[c] - CntW'(strobe_q[c]) + CntW'(credit_ret[c]);
            end
        end
    end

    // A beat on the strobe still holds its credit this cycle
    always_comb begin
        for (int c = 0; c < 2; c++) begin
            has_credit[c] = credit_q[c] > CntW'(strobe_q[c]);
        end
    end

    assign mem_has_credit_o = has_credit[USER_MEMORY];
    assign snp_has_credit_o = has_credit[USER_SNOOP];
    assign mem_valid_o      = strobe_q[USER_MEMORY];
    assign snp_valid_o      = strobe_q[USER_SNOOP];

    // Payload
    always_ff @(posedge clk_i) begin
        if (fwd_valid_i) begin
            out_data_o <= fwd_data_i;
            out_last_o <= fwd_last_i;
        end
    end

endmodule

// ==== logic/cd_order_queue.sv ====
//////////////////////////////////////////////////
// Snoop data ordering queue
// Fall-through FIFO of pending snoop data requests
//////////////////////////////////////////////////

module cd_order_queue #(
    parameter int unsigned NumMst     = 4,
    parameter int unsigned QueueDepth = 4,
    localparam int unsigned IdxW      = (NumMst > 1) ? $clog2(NumMst) : 1
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      req_valid_i,
    input  snoop_data_pkg::cd_user_e  req_user_i,
    input  logic [IdxW-1:0]           req_first_i,
    input  logic [NumMst-1:0]         req_avail_i,
    output logic                      req_ready_o,
    input  logic                      pop_i,
    output logic                      head_valid_o,
    output snoop_data_pkg::cd_user_e  head_user_o,
    output logic [IdxW-1:0]           head_first_o,
    output logic [NumMst-1:0]         head_avail_o
);
    import snoop_data_pkg::*;

    localparam int unsigned PtrW = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
    localparam int unsigned CntW = $clog2(QueueDepth + 1);

    // Entry storage
    cd_user_e          user_q  [QueueDepth];
    logic [IdxW-1:0]   first_q [QueueDepth];
    logic [NumMst-1:0] avail_q [QueueDepth];

    logic [PtrW-1:0] wr_ptr_q;
    logic [PtrW-1:0] rd_ptr_q;
    logic [CntW-1:0] count_q;
    logic            empty;
    logic            push;
    logic            pop;

    assign empty       = (count_q == '0);
    assign req_ready_o = (count_q != CntW'(QueueDepth));
    assign push        = req_valid_i && req_ready_o;
    assign pop         = pop_i && head_valid_o;

    // Empty queue bypasses the incoming request to the head
    assign head_valid_o = !empty || req_valid_i;
    assign head_user_o  = empty ? req_user_i  : user_q[rd_ptr_q];
    assign head_first_o = empty ? req_first_i : first_q[rd_ptr_q];
    assign head_avail_o = empty ? req_avail_i : avail_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push) begin
            user_q[wr_ptr_q]  <= req_user_i;
            first_q[wr_ptr_q] <= req_first_i;
            avail_q[wr_ptr_q] <= req_avail_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PtrW'(QueueDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PtrW'(QueueDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CntW'(push) - CntW'(pop);
        end
    end

endmodule

// ==== logic/snoop_data_ctrl.sv ====
//////////////////////////////////////////////////
// Snoop data collector top level
// Ordering queue, beat tracker and credit output
//////////////////////////////////////////////////

module snoop_data_ctrl #(
    parameter int unsigned NumMst     = snoop_data_pkg::DefaultNumMst,
    parameter int unsigned DataWidth  = snoop_data_pkg::DefaultDataWidth,
    parameter int unsigned QueueDepth = snoop_data_pkg::DefaultQueueDepth,
    parameter int unsigned Credits    = snoop_data_pkg::DefaultCredits,
    localparam int unsigned IdxW      = (NumMst > 1) ? $clog2(NumMst) : 1
) (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    // Request port
    input  logic                              req_valid_i,
    input  snoop_data_pkg::cd_user_e          req_user_i,
    input  logic [IdxW-1:0]                   req_first_i,
    input  logic [NumMst-1:0]                 req_avail_i,
    output logic                              req_ready_o,
    // Snoop data channels
    input  logic [NumMst-1:0]                 cd_valid_i,
    input  logic [NumMst-1:0][DataWidth-1:0]  cd_data_i,
    input  logic [NumMst-1:0]                 cd_last_i,
    output logic [NumMst-1:0]                 cd_ready_o,
    // Consumer outputs
    output logic [DataWidth-1:0]              out_data_o,
    output logic                              out_last_o,
    output logic                              mem_valid_o,
    output logic                              snp_valid_o,
    input  logic                              mem_credit_i,
    input  logic                              snp_credit_i
);
    import snoop_data_pkg::*;

    logic                 head_valid;
    cd_user_e             head_user;
    logic [IdxW-1:0]      head_first;
    logic [NumMst-1:0]    head_avail;
    logic                 pop;

    logic                 fwd_valid;
    cd_user_e             fwd_user;
    logic [DataWidth-1:0] fwd_data;
    logic                 fwd_last;

    logic                 mem_has_credit;
    logic                 snp_has_credit;

    cd_order_queue #(
        .NumMst     (NumMst),
        .QueueDepth (QueueDepth)
    ) u_order_queue (
        .clk_i,
        .rst_ni,
        .req_valid_i,
        .req_user_i,
        .req_first_i,
        .req_avail_i,
        .req_ready_o,
        .pop_i        (pop),
        .head_valid_o (head_valid),
        .head_user_o  (head_user),
        .head_first_o (head_first),
        .head_avail_o (head_avail)
    );

    cd_beat_tracker #(
        .NumMst    (NumMst),
        .DataWidth (DataWidth)
    ) u_beat_tracker (
        .clk_i,
        .rst_ni,
        .head_valid_i     (head_valid),
        .head_user_i      (head_user),
        .head_first_i     (head_first),
        .head_avail_i     (head_avail),
        .pop_o            (pop),
        .mem_has_credit_i (mem_has_credit),
        .snp_has_credit_i (snp_has_credit),
        .cd_valid_i,
        .cd_data_i,
        .cd_last_i,
        .cd_ready_o,
        .fwd_valid_o      (fwd_valid),
        .fwd_user_o       (fwd_user),
        .fwd_data_o       (fwd_data),
        .fwd_last_o       (fwd_last)
    );

    cd_credit_out #(
        .NumMst    (NumMst),
        .DataWidth (DataWidth),
        .Credits   (Credits)
    ) u_credit_out (
        .clk_i,
        .rst_ni,
        .fwd_valid_i      (fwd_valid),
        .fwd_user_i       (fwd_user),
        .fwd_data_i       (fwd_data),
        .fwd_last_i       (fwd_last),
        .mem_credit_i,
        .snp_credit_i,
        .mem_has_credit_o (mem_has_credit),
        .snp_has_credit_o (snp_has_credit),
        .mem_valid_o,
        .snp_valid_o,
        .out_data_o,
        .out_last_o
    );

endmodule

// ==== logic/snoop_data_pkg.sv ====
//////////////////////////////////////////////////
// Snoop data collector shared definitions
// Consumer encoding and default sizes
//////////////////////////////////////////////////

package snoop_data_pkg;

    // Unit that consumes the snoop data of a request
    typedef enum logic {
        USER_MEMORY = 1'b0,
        USER_SNOOP  = 1'b1
    } cd_user_e;

    // Number of snooped masters
    localparam int unsigned DefaultNumMst = 4;

    // Width of one snoop data beat
    localparam int unsigned DefaultDataWidth = 64;

    // Entries in the ordering queue
    localparam int unsigned DefaultQueueDepth = 4;

    // Credits per consumer
    localparam int unsigned DefaultCredits = 4;

endpackage

// ==== tests/snoop_data_ctrl_properties.sv ====
//////////////////////////////////////////////////
// Protocol checks for the snoop data collector
//////////////////////////////////////////////////

module snoop_data_ctrl_properties #(
    parameter int unsigned NumMst = 4
) (
    input logic              clk_i,
    input logic              rst_ni,
    input logic              head_valid_i,
    input logic [NumMst-1:0] cd_ready_i,
    input logic              req_ready_i,
    input logic              mem_valid_i,
    input logic              snp_valid_i,
    input logic              mem_cnt_zero_i,
    input logic              snp_cnt_zero_i
);
    int fail_count = 0;

    // One consumer strobe at a time
    one_consumer: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(mem_valid_i && snp_valid_i)) else begin
        fail_count++;
        $error("memory and snoop strobes are high together");
    end

    // Nothing accepted without a pending request
    ready_needs_head: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !head_valid_i |-> cd_ready_i == '0) else begin
        fail_count++;
        $error("snoop data ready while the ordering queue is empty");
    end

    strobe_needs_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (!mem_valid_i || !mem_cnt_zero_i) && (!snp_valid_i || !snp_cnt_zero_i)) else begin
        fail_count++;
        $error("output strobe while the consumer has no credit");
    end

    reset_quiet: assert property (@(posedge clk_i)
        !rst_ni |-> !mem_valid_i && !snp_valid_i && cd_ready_i == '0 && req_ready_i) else begin
        fail_count++;
        $error("outputs active during reset");
    end

endmodule

bind snoop_data_ctrl snoop_data_ctrl_properties #(
    .NumMst (NumMst)
) props_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .head_valid_i   (head_valid),
    .cd_ready_i     (cd_ready_o),
    .req_ready_i    (req_ready_o),
    .mem_valid_i    (mem_valid_o),
    .snp_valid_i    (snp_valid_o),
    .mem_cnt_zero_i (u_credit_out.credit_q[0] == '0),
    .snp_cnt_zero_i (u_credit_out.credit_q[1] == '0)
);

// ==== tests/tb_snoop_data_ctrl.sv ====
//////////////////////////////////////////////////
// Testbench for the snoop data collector
// Random masters, model queue and output monitor
//////////////////////////////////////////////////

module tb_snoop_data_ctrl;
    import snoop_data_pkg::*;

    localparam int NumMst  = DefaultNumMst;
    localparam int DataW   = DefaultDataWidth;
    localparam int IdxW    = $clog2(NumMst);
    localparam int Timeout = 400;

    typedef struct packed {
        cd_user_e         user;
        logic [DataW-1:0] data;
        logic             last;
    } beat_t;

    typedef struct packed {
        cd_user_e          user;
        logic [IdxW-1:0]   first;
        logic [NumMst-1:0] avail;
    } req_t;

    logic                         clk        = 1'b0;
    logic                         rst_n      = 1'b1;
    logic                         req_valid  = 1'b0;
    cd_user_e                     req_user   = USER_MEMORY;
    logic [IdxW-1:0]              req_first  = '0;
    logic [NumMst-1:0]            req_avail  = '0;
    logic [NumMst-1:0]            cd_valid   = '0;
    logic [NumMst-1:0][DataW-1:0] cd_data    = '0;
    logic [NumMst-1:0]            cd_last    = '0;
    logic                         mem_credit = 1'b0;
    logic                         snp_credit = 1'b0;
    logic                         req_ready;
    logic [NumMst-1:0]            cd_ready;
    logic [DataW-1:0]             out_data;
    logic                         out_last;
    logic                         mem_valid;
    logic                         snp_valid;

    // Master and consumer state
    int    beats_left [NumMst];
    int    next_burst [NumMst];
    logic  credit_stall = 1'b0;
    int    mem_owed = 0;
    int    snp_owed = 0;
    // Reference model
    beat_t exp_q [$];
    req_t  req_q [$];
    logic [NumMst-1:0] seen_last = '0;
    // First-responder beat accepted in the previous cycle
    logic  fwd_seen = 1'b0;
    int    mem_count = 0;
    int    snp_count = 0;
    int    mem_base = 0;
    int    snp_base = 0;
    int    mismatches = 0;
    int    failures = 0;
    string test_name = "reset_state";

    snoop_data_ctrl dut_i (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .req_valid_i  (req_valid),
        .req_user_i   (req_user),
        .req_first_i  (req_first),
        .req_avail_i  (req_avail),
        .req_ready_o  (req_ready),
        .cd_valid_i   (cd_valid),
        .cd_data_i    (cd_data),
        .cd_last_i    (cd_last),
        .cd_ready_o   (cd_ready),
        .out_data_o   (out_data),
        .out_last_o   (out_last),
        .mem_valid_o  (mem_valid),
        .snp_valid_o  (snp_valid),
        .mem_credit_i (mem_credit),
        .snp_credit_i (snp_credit)
    );

    always #4 clk = ~clk;

    task automatic report_mismatch(input string what, input logic [DataW-1:0] expected,
                                   input logic [DataW-1:0] actual);
        mismatches++;
        $display("mismatch in %s: %s expected %0h actual %0h", test_name, what, expected, actual);
    endtask

    task automatic report_failure(input string what);
        failures++;
        $display("failure in %s: %s", test_name, what);
    endtask

    //////////////////////////////////////////////////
    // Masters and consumers
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        int left;
        for (int i = 0; i < NumMst; i++) begin
            left = beats_left[i];
            if (cd_valid[i] && cd_ready[i]) begin
                left = cd_last[i] ? next_burst[i] : left - 1;
                beats_left[i] <= left;
                if (cd_last[i]) begin
                    next_burst[i] <= 0;
                end
            end
            // A presented beat holds until accepted
            if (!cd_valid[i] || cd_ready[i]) begin
                cd_valid[i] <= (left > 0) && ($urandom_range(3, 0) != 0);
                cd_data[i]  <= {$urandom, $urandom};
                cd_last[i]  <= (left == 1);
            end
        end
    end

    // One credit back per strobe, unless the consumer stalls
    always @(posedge clk) begin
        int m_owed;
        int s_owed;
        m_owed = mem_owed + int'(mem_valid);
        s_owed = snp_owed + int'(snp_valid);
        mem_credit <= !credit_stall && (m_owed > 0);
        snp_credit <= !credit_stall && (s_owed > 0);
        mem_owed   <= (!credit_stall && m_owed > 0) ? m_owed - 1 : m_owed;
        snp_owed   <= (!credit_stall && s_owed > 0) ? s_owed - 1 : s_owed;
    end

    //////////////////////////////////////////////////
    // Monitor
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        beat_t             exp;
        req_t              head;
        logic [NumMst-1:0] hs;
        if (rst_n) begin
            assert ((mem_valid || snp_valid) == fwd_seen)
                else report_mismatch("strobe one cycle after the beat", fwd_seen,
                                     mem_valid || snp_valid);
            fwd_seen = 1'b0;
            if (mem_valid || snp_valid) begin
                mem_count <= mem_count + int'(mem_valid);
                snp_count <= snp_count + int'(snp_valid);
                if (exp_q.size() == 0) begin
                    report_failure("output strobe without an accepted first-responder beat");
                end else begin
                    exp = exp_q.pop_front();
                    assert (mem_valid == (exp.user == USER_MEMORY))
                        else report_mismatch("consumer", exp.user, snp_valid);
                    assert (out_data == exp.data) else report_mismatch("data", exp.data, out_data);
                    assert (out_last == exp.last) else report_mismatch("last", exp.last, out_last);
                end
            end
            if (req_valid && req_ready) begin
                req_q.push_back('{req_user, req_first, req_avail});
            end
            hs = cd_valid & cd_ready;
            if (hs != '0 && req_q.size() == 0) begin
                report_failure("snoop beat accepted with no request pending");
            end else if (hs != '0) begin
                head = req_q[0];
                assert ((hs & ~head.avail) == '0)
                    else report_mismatch("masters outside the mask", '0, hs & ~head.avail);
                assert ((hs & seen_last) == '0)
                    else report_mismatch("beats after last", '0, hs & seen_last);
                if (hs[head.first]) begin
                    exp_q.push_back('{head.user, cd_data[head.first], cd_last[head.first]});
                    fwd_seen = 1'b1;
                end
                seen_last = seen_last | (hs & cd_last);
                if (seen_last == head.avail) begin
                    void'(req_q.pop_front());
                    seen_last = '0;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Sequences
    //////////////////////////////////////////////////

    task automatic push_request(input cd_user_e user, input int first,
                                input logic [NumMst-1:0] avail);
        int waited;
        waited = 0;
        @(posedge clk);
        req_valid <= 1'b1;
        req_user  <= user;
        req_first <= IdxW'(first);
        req_avail <= avail;
        do begin
            @(posedge clk);
            waited++;
        end while (!req_ready && waited < Timeout);
        if (!req_ready) begin
            report_failure("request was not accepted before the timeout");
        end
        req_valid <= 1'b0;
    endtask

    task automatic send_bursts(input int m, input int first_len, input int second_len);
        beats_left[m] <= first_len;
        next_burst[m] <= second_len;
    endtask

    function automatic logic busy();
        logic b;
        b = (cd_valid != '0) || (req_q.size() != 0) || (exp_q.size() != 0);
        b = b || (mem_owed != 0) || (snp_owed != 0);
        for (int i = 0; i < NumMst; i++) begin
            b = b || (beats_left[i] != 0) || (next_burst[i] != 0);
        end
        return b;
    endfunction

    task automatic wait_idle();
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (busy() && waited < Timeout);
        if (busy()) begin
            report_failure("traffic did not drain before the timeout");
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        mem_base  = mem_count;
        snp_base  = snp_count;
    endtask

    task automatic check_counts(input int mem_exp, input int snp_exp);
        assert (mem_count - mem_base == mem_exp)
            else report_mismatch("memory beats", mem_exp, mem_count - mem_base);
        assert (snp_count - snp_base == snp_exp)
            else report_mismatch("snoop beats", snp_exp, snp_count - snp_base);
    endtask

    task automatic check_quiet();
        assert (req_ready) else report_mismatch("req_ready_o", 1, req_ready);
        assert (cd_ready == '0) else report_mismatch("cd_ready_o", '0, cd_ready);
        assert (!mem_valid && !snp_valid)
            else report_mismatch("strobes", '0, {mem_valid, snp_valid});
    endtask

    initial begin
        int                waited;
        int                m;
        int                skip;
        int                first_a;
        int                first_b;
        int                len_a [NumMst];
        int                len_b [NumMst];
        logic [NumMst-1:0] mask;
        void'($urandom(30));

        // Three cycles of reset
        rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_quiet();
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_quiet();

        start_test("memory_routing");
        m = $urandom_range(NumMst - 1, 0);
        push_request(USER_MEMORY, m, NumMst'(1 << m));
        send_bursts(m, 4, 0);
        wait_idle();
        check_counts(4, 0);

        start_test("snoop_routing");
        m = $urandom_range(NumMst - 1, 0);
        push_request(USER_SNOOP, m, NumMst'(1 << m));
        send_bursts(m, 4, 0);
        wait_idle();
        check_counts(0, 4);

        // Second request spans every master, so early beats would be visible
        start_test("multiple_responders");
        skip    = $urandom_range(NumMst - 1, 0);
        mask    = ~(NumMst'(1) << skip);
        first_a = (skip + 1 + $urandom_range(NumMst - 2, 0)) % NumMst;
        first_b = $urandom_range(NumMst - 1, 0);
        push_request(USER_MEMORY, first_a, mask);
        push_request(USER_SNOOP, first_b, '1);
        for (int i = 0; i < NumMst; i++) begin
            len_a[i] = mask[i] ? $urandom_range(4, 1) : 0;
            len_b[i] = $urandom_range(3, 1);
            if (mask[i]) begin
                send_bursts(i, len_a[i], len_b[i]);
            end else begin
                send_bursts(i, len_b[i], 0);
            end
        end
        wait_idle();
        check_counts(len_a[first_a], len_b[first_b]);

        start_test("credit_backpressure");
        credit_stall <= 1'b1;
        m = $urandom_range(NumMst - 1, 0);
        push_request(USER_MEMORY, m, NumMst'(1 << m));
        send_bursts(m, DefaultCredits + 3, 0);
        waited = 0;
        while (mem_count - mem_base < DefaultCredits && waited < Timeout) begin
            @(negedge clk);
            waited++;
        end
        if (mem_count - mem_base < DefaultCredits) begin
            report_failure("credit-limited beats did not reach the output");
        end
        repeat (10) begin
            @(negedge clk);
            assert (!cd_ready[m]) else report_mismatch("ready without credit", 0, cd_ready[m]);
        end
        check_counts(DefaultCredits, 0);
        credit_stall <= 1'b0;
        wait_idle();
        check_counts(DefaultCredits + 3, 0);

        start_test("queue_full");
        for (int i = 0; i < DefaultQueueDepth; i++) begin
            push_request(USER_SNOOP, i % NumMst, NumMst'(1 << (i % NumMst)));
        end
        @(negedge clk);
        assert (!req_ready) else report_mismatch("req_ready_o when full", 0, req_ready);
        send_bursts(0, 2, 0);
        waited = 0;
        while (!req_ready && waited < Timeout) begin
            @(negedge clk);
            waited++;
        end
        if (!req_ready) begin
            report_failure("req_ready_o did not rise after the head request retired");
        end
        assert (req_q.size() < DefaultQueueDepth)
            else report_failure("req_ready_o rose before the head request retired");
        for (int i = 1; i < DefaultQueueDepth; i++) begin
            send_bursts(i % NumMst, 2, 0);
        end
        wait_idle();
        check_counts(0, 2 * DefaultQueueDepth);

        repeat (2) @(negedge clk);
        $display("Error counts: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, failures, dut_i.props_i.fail_count);
        if (mismatches == 0 && failures == 0 && dut_i.props_i.fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
